//--- source/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    typedef enum logic [1:0] {
        size_byte = 2'b01,  // 2'b00 unused
        size_half = 2'b10,
        size_word = 2'b11
    } lsu_size_e;

    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } lsu_op_e;

    typedef enum logic [2:0] {
        st_idle,
        st_addr_rd,
        st_wait_r,
        st_addr_wr,
        st_data_wr,
        st_wait_b,
        st_done
    } lsu_state_e;

endpackage

`default_nettype wire

//--- source/mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

    localparam logic [31:0] sram_base  = 32'h8000_0000;
    localparam logic [31:0] clint_base = 32'h0200_0000;
    localparam logic [31:0] clint_size = 32'h0001_0000;

    // mtime register offsets inside the clint window
    localparam logic [15:0] mtime_lo_off = 16'hbff8;
    localparam logic [15:0] mtime_hi_off = 16'hbffc;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } bus_resp_e;

endpackage

`default_nettype wire

//--- source/lsu.sv
`timescale 1ns/10ps
`default_nettype none

module lsu
    import lsu_pkg::*;
    import mem_map_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire              req,
    input  wire lsu_op_e     op,
    input  wire lsu_size_e   size,
    input  wire              sign,
    input  wire [31:0]       addr,
    input  wire [31:0]       wdata,
    output logic [31:0]      rdata,
    output logic             done,
    output logic             err,
    output logic             busy,
    output logic             arvalid,
    input  wire              arready,
    output logic [31:0]      araddr,
    input  wire              rvalid,
    output logic             rready,
    input  wire [31:0]       rdata_bus,
    input  wire bus_resp_e   rresp,
    output logic             awvalid,
    input  wire              awready,
    output logic [31:0]      awaddr,
    output logic             wvalid,
    input  wire              wready,
    output logic [31:0]      wdata_bus,
    output logic [3:0]       wstrb,
    input  wire              bvalid,
    output logic             bready,
    input  wire bus_resp_e   bresp
);

    lsu_state_e  state;
    lsu_op_e     op_q;
    lsu_size_e   size_q;
    logic        sign_q;
    logic [31:0] addr_q;
    logic [31:0] wdata_q;
    logic [31:0] rword_q;
    logic        resp_err_q;
    logic [31:0] shifted;
    logic [31:0] ext;
    logic        accept;

    assign accept = req && !busy;
    assign busy   = (state != st_idle);

    assign arvalid = (state == st_addr_rd);
    assign araddr  = addr_q;
    assign rready  = (state == st_wait_r);
    assign awvalid = (state == st_addr_wr);
    assign awaddr  = addr_q;
    assign wvalid  = (state == st_data_wr);
    assign bready  = (state == st_wait_b);

    // byte lanes for the store
    always_comb begin
        case (size_q)
            size_byte: wstrb = 4'b0001 << addr_q[1:0];
            size_half: wstrb = addr_q[1] ? 4'b1100 : 4'b0011;
            default:   wstrb = 4'b1111;
        endcase
    end

    assign wdata_bus = wdata_q << {addr_q[1:0], 3'b000};
    assign shifted   = rword_q >> {addr_q[1:0], 3'b000};

    always_comb begin
        case (size_q)
            size_byte: ext = {{24{sign_q & shifted[7]}}, shifted[7:0]};
            size_half: ext = {{16{sign_q & shifted[15]}}, shifted[15:0]};
            default:   ext = shifted;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            done  <= 1'b0;
            err   <= 1'b0;
            rdata <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= (op == op_load) ? st_addr_rd : st_addr_wr;
                    end
                end
                st_addr_rd: if (arready) state <= st_wait_r;
                st_wait_r:  if (rvalid) state <= st_done;
                st_addr_wr: if (awready) state <= st_data_wr;
                st_data_wr: if (wready) state <= st_wait_b;
                st_wait_b:  if (bvalid) state <= st_done;
                st_done: begin
                    done  <= 1'b1;
                    err   <= resp_err_q;
                    rdata <= (op_q == op_load) ? ext : '0;
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= op;
            size_q  <= size;
            sign_q  <= sign;
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (rvalid && rready) begin
            rword_q    <= rdata_bus;
            resp_err_q <= (rresp != resp_okay);
        end
        if (bvalid && bready) begin
            resp_err_q <= (bresp != resp_okay);
        end
    end

    a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (accept && size != size_byte) |->
            (addr[0] == 1'b0 && (size != size_word || addr[1] == 1'b0)))
        else $error("lsu: misaligned request accepted");

    // w follows the address handshake of the same store
    a_w_after_aw: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(wvalid) |-> $past(awvalid && awready))
        else $error("lsu: wvalid raised before aw handshake");

endmodule

`default_nettype wire

//--- source/lsu_xbar.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_xbar
    import mem_map_pkg::*;
#(
    parameter int sram_words = 1024
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              arvalid,
    output logic             arready,
    input  wire [31:0]       araddr,
    output logic             rvalid,
    input  wire              rready,
    output logic [31:0]      rdata,
    output bus_resp_e        rresp,
    input  wire              awvalid,
    output logic             awready,
    input  wire [31:0]       awaddr,
    input  wire              wvalid,
    output logic             wready,
    input  wire [31:0]       wdata,
    input  wire [3:0]        wstrb,
    output logic             bvalid,
    input  wire              bready,
    output bus_resp_e        bresp,
    output logic             s_arvalid,
    input  wire              s_arready,
    output logic [31:0]      s_araddr,
    input  wire              s_rvalid,
    output logic             s_rready,
    input  wire [31:0]       s_rdata,
    input  wire bus_resp_e   s_rresp,
    output logic             s_awvalid,
    input  wire              s_awready,
    output logic [31:0]      s_awaddr,
    output logic             s_wvalid,
    input  wire              s_wready,
    output logic [31:0]      s_wdata,
    output logic [3:0]       s_wstrb,
    input  wire              s_bvalid,
    output logic             s_bready,
    input  wire bus_resp_e   s_bresp,
    output logic             c_arvalid,
    input  wire              c_arready,
    output logic [31:0]      c_araddr,
    input  wire              c_rvalid,
    output logic             c_rready,
    input  wire [31:0]       c_rdata,
    input  wire bus_resp_e   c_rresp
);

    typedef enum logic [1:0] {
        tgt_sram,
        tgt_clint,
        tgt_none
    } tgt_e;

    localparam logic [31:0] sram_end = sram_base + 32'(sram_words * 4);

    tgt_e      ar_tgt;
    tgt_e      aw_tgt;
    tgt_e      tgt_q;
    logic      open_q;
    logic      err_r_q;
    logic      err_w_q;
    logic      err_b_q;
    bus_resp_e err_resp;

    function automatic tgt_e decode(input logic [31:0] a);
        if (a >= sram_base && a < sram_end) begin
            return tgt_sram;
        end
        if (a >= clint_base && a < clint_base + clint_size) begin
            return tgt_clint;
        end
        return tgt_none;
    endfunction

    assign ar_tgt = decode(araddr);
    assign aw_tgt = decode(awaddr);

    // address phase uses the live address
    assign s_arvalid = arvalid && !open_q && (ar_tgt == tgt_sram);
    assign c_arvalid = arvalid && !open_q && (ar_tgt == tgt_clint);
    assign s_araddr  = araddr;
    assign c_araddr  = araddr;
    assign s_awvalid = awvalid && !open_q && (aw_tgt == tgt_sram);
    assign s_awaddr  = awaddr;
    assign awready   = !open_q && ((aw_tgt == tgt_sram) ? s_awready : 1'b1);

    always_comb begin
        case (ar_tgt)
            tgt_sram:  arready = !open_q && s_arready;
            tgt_clint: arready = !open_q && c_arready;
            default:   arready = !open_q;  // error responder
        endcase
    end

    // data and response phases follow the held target
    assign s_rready = rready && open_q && (tgt_q == tgt_sram);
    assign c_rready = rready && open_q && (tgt_q == tgt_clint);
    assign s_wvalid = wvalid && open_q && (tgt_q == tgt_sram);
    assign s_wdata  = wdata;
    assign s_wstrb  = wstrb;
    assign s_bready = bready && open_q && (tgt_q == tgt_sram);
    assign err_resp = (tgt_q == tgt_clint) ? resp_slverr : resp_decerr;

    always_comb begin
        case (tgt_q)
            tgt_sram: begin
                rvalid = s_rvalid;
                rdata  = s_rdata;
                rresp  = s_rresp;
                wready = s_wready;
                bvalid = s_bvalid;
                bresp  = s_bresp;
            end
            tgt_clint: begin
                rvalid = c_rvalid;
                rdata  = c_rdata;
                rresp  = c_rresp;
                wready = err_w_q;  // clint is read-only
                bvalid = err_b_q;
                bresp  = err_resp;
            end
            default: begin
                rvalid = err_r_q;
                rdata  = '0;
                rresp  = err_resp;
                wready = err_w_q;
                bvalid = err_b_q;
                bresp  = err_resp;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            open_q  <= 1'b0;
            tgt_q   <= tgt_sram;
            err_r_q <= 1'b0;
            err_w_q <= 1'b0;
            err_b_q <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                open_q  <= 1'b1;
                tgt_q   <= ar_tgt;
                err_r_q <= (ar_tgt == tgt_none);
            end else if (awvalid && awready) begin
                open_q  <= 1'b1;
                tgt_q   <= aw_tgt;
                err_w_q <= (aw_tgt != tgt_sram);
            end
            if (wvalid && wready && err_w_q) begin
                err_w_q <= 1'b0;
                err_b_q <= 1'b1;
            end
            if (rvalid && rready) begin
                open_q  <= 1'b0;
                err_r_q <= 1'b0;
            end
            if (bvalid && bready) begin
                open_q  <= 1'b0;
                err_b_q <= 1'b0;
            end
        end
    end

    a_single_txn: assert property (@(posedge clk) disable iff (!rst_n)
        open_q |-> !(arvalid || awvalid))
        else $error("lsu_xbar: address valid while a transaction is open");

endmodule

`default_nettype wire

//--- source/sram_slave.sv
`timescale 1ns/10ps
`default_nettype none

module sram_slave
    import mem_map_pkg::*;
#(
    parameter int sram_words = 1024
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              arvalid,
    output logic             arready,
    input  wire [31:0]       araddr,
    output logic             rvalid,
    input  wire              rready,
    output logic [31:0]      rdata,
    output bus_resp_e        rresp,
    input  wire              awvalid,
    output logic             awready,
    input  wire [31:0]       awaddr,
    input  wire              wvalid,
    output logic             wready,
    input  wire [31:0]       wdata,
    input  wire [3:0]        wstrb,
    output logic             bvalid,
    input  wire              bready,
    output bus_resp_e        bresp
);

    localparam int idx_w = $clog2(sram_words);

    logic [31:0]      mem [sram_words];
    logic             aw_held_q;
    logic [idx_w-1:0] widx_q;
    logic             idle;

    assign idle    = !rvalid && !bvalid && !aw_held_q;
    assign arready = idle;
    assign awready = idle;
    assign wready  = aw_held_q;  // only after the write address
    assign rresp   = resp_okay;
    assign bresp   = resp_okay;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < sram_words; i++) begin
                mem[i] <= '0;
            end
            rvalid    <= 1'b0;
            bvalid    <= 1'b0;
            aw_held_q <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (awvalid && awready) begin
                aw_held_q <= 1'b1;
            end
            if (wvalid && wready) begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) mem[widx_q][8*b +: 8] <= wdata[8*b +: 8];
                end
                aw_held_q <= 1'b0;
                bvalid    <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata <= mem[araddr[idx_w+1:2]];
        end
        if (awvalid && awready) begin
            widx_q <= awaddr[idx_w+1:2];
        end
    end

endmodule

`default_nettype wire

//--- source/clint_slave.sv
`timescale 1ns/10ps
`default_nettype none

module clint_slave
    import mem_map_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         arvalid,
    output logic        arready,
    input  wire [31:0]  araddr,
    output logic        rvalid,
    input  wire         rready,
    output logic [31:0] rdata,
    output bus_resp_e   rresp
);

    logic [63:0] mtime;
    logic [15:0] offset;
    logic        hit;

    assign offset  = araddr[15:0];  // window is 64k aligned
    assign hit     = (offset == mtime_lo_off) || (offset == mtime_hi_off);
    assign arready = !rvalid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime  <= '0;
            rvalid <= 1'b0;
            rresp  <= resp_okay;
        end else begin
            mtime <= mtime + 64'd1;
            if (arvalid && arready) begin
                rvalid <= 1'b1;
                rresp  <= hit ? resp_okay : resp_slverr;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            case (offset)
                mtime_lo_off: rdata <= mtime[31:0];
                mtime_hi_off: rdata <= mtime[63:32];
                default:      rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/mem_subsys_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_top
    import lsu_pkg::*;
    import mem_map_pkg::*;
#(
    parameter int sram_words = 1024
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              req,
    input  wire lsu_op_e     op,
    input  wire lsu_size_e   size,
    input  wire              sign,
    input  wire [31:0]       addr,
    input  wire [31:0]       wdata,
    output logic [31:0]      rdata,
    output logic             done,
    output logic             err,
    output logic             busy
);

    logic        arvalid, arready, rvalid, rready;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic [31:0] araddr, awaddr, rdata_bus, wdata_bus;
    logic [3:0]  wstrb;
    bus_resp_e   rresp, bresp;

    logic        s_arvalid, s_arready, s_rvalid, s_rready;
    logic        s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
    logic [31:0] s_araddr, s_awaddr, s_rdata, s_wdata;
    logic [3:0]  s_wstrb;
    bus_resp_e   s_rresp, s_bresp;

    logic        c_arvalid, c_arready, c_rvalid, c_rready;
    logic [31:0] c_araddr, c_rdata;
    bus_resp_e   c_rresp;

    lsu u_lsu (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .op        (op),
        .size      (size),
        .sign      (sign),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata),
        .done      (done),
        .err       (err),
        .busy      (busy),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata_bus (rdata_bus),
        .rresp     (rresp),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata_bus (wdata_bus),
        .wstrb     (wstrb),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp)
    );

    lsu_xbar #(
        .sram_words (sram_words)
    ) u_lsu_xbar (
        .clk       (clk),
        .rst_n     (rst_n),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata_bus),
        .rresp     (rresp),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata_bus),
        .wstrb     (wstrb),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_araddr  (s_araddr),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_awaddr  (s_awaddr),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_wdata   (s_wdata),
        .s_wstrb   (s_wstrb),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_bresp   (s_bresp),
        .c_arvalid (c_arvalid),
        .c_arready (c_arready),
        .c_araddr  (c_araddr),
        .c_rvalid  (c_rvalid),
        .c_rready  (c_rready),
        .c_rdata   (c_rdata),
        .c_rresp   (c_rresp)
    );

    sram_slave #(
        .sram_words (sram_words)
    ) u_sram_slave (
        .clk     (clk),
        .rst_n   (rst_n),
        .arvalid (s_arvalid),
        .arready (s_arready),
        .araddr  (s_araddr),
        .rvalid  (s_rvalid),
        .rready  (s_rready),
        .rdata   (s_rdata),
        .rresp   (s_rresp),
        .awvalid (s_awvalid),
        .awready (s_awready),
        .awaddr  (s_awaddr),
        .wvalid  (s_wvalid),
        .wready  (s_wready),
        .wdata   (s_wdata),
        .wstrb   (s_wstrb),
        .bvalid  (s_bvalid),
        .bready  (s_bready),
        .bresp   (s_bresp)
    );

    clint_slave u_clint_slave (
        .clk     (clk),
        .rst_n   (rst_n),
        .arvalid (c_arvalid),
        .arready (c_arready),
        .araddr  (c_araddr),
        .rvalid  (c_rvalid),
        .rready  (c_rready),
        .rdata   (c_rdata),
        .rresp   (c_rresp)
    );

endmodule

`default_nettype wire

//--- verification/mem_checker.sv
`timescale 1ns/10ps
`default_nettype none

module mem_checker
    import lsu_pkg::*;
    import mem_map_pkg::*;
#(
    parameter int sram_words = 1024
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              req,
    input  wire lsu_op_e     op,
    input  wire lsu_size_e   size,
    input  wire              sign,
    input  wire [31:0]       addr,
    input  wire [31:0]       wdata,
    input  wire [31:0]       rdata,
    input  wire              done,
    input  wire              err,
    input  wire              busy,
    input  wire [3:0]        kind,
    input  wire [31:0]       expect_val,
    input  wire [7:0]        index,
    output int               value_errs,
    output int               proto_errs,
    output int               done_count
);

    logic [7:0]  model [sram_words*4];  // sram image with one byte per entry
    logic        pending;
    logic        started;
    logic        have_mtime;
    logic [31:0] last_mtime;
    lsu_op_e     op_q;
    lsu_size_e   size_q;
    logic        sign_q;
    logic [31:0] addr_q;
    logic [31:0] wdata_q;
    logic [31:0] exp_q;
    logic [3:0]  kind_q;
    logic [7:0]  index_q;

    initial begin
        for (int i = 0; i < sram_words * 4; i++) begin
            model[i] = 8'h00;
        end
        pending    = 1'b0;
        started    = 1'b0;
        have_mtime = 1'b0;
        last_mtime = '0;
        value_errs = 0;
        proto_errs = 0;
        done_count = 0;
    end

    function automatic int nbytes(input lsu_size_e s);
        case (s)
            size_byte: return 1;
            size_half: return 2;
            default:   return 4;
        endcase
    endfunction

    function automatic string kind_label(input logic [3:0] k, input lsu_op_e o);
        case (k)
            4'd1:    return "literal_load";
            4'd2:    return "mtime_read";
            4'd3:    return "error_access";
            default: return (o == op_store) ? "sram_store" : "sram_load";
        endcase
    endfunction

    // little endian gather and sign fill above the top byte
    function automatic logic [31:0] predict_load(input logic [31:0] a, input lsu_size_e s,
                                                 input logic sgn);
        logic [31:0] off;
        logic [31:0] val;
        int          n;
        off = a - sram_base;
        n   = nbytes(s);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val[8*i +: 8] = model[off + i];
        end
        if (sgn && val[8*n-1]) begin
            for (int i = n; i < 4; i++) begin
                val[8*i +: 8] = 8'hff;
            end
        end
        return val;
    endfunction

    task automatic apply_store(input logic [31:0] a, input lsu_size_e s, input logic [31:0] d);
        logic [31:0] off;
        off = a - sram_base;
        for (int i = 0; i < nbytes(s); i++) begin
            model[off + i] = d[8*i +: 8];
        end
    endtask

    task automatic expect_err(input string name, input logic want);
        if (err !== want) begin
            $display("FAIL %s err: expected %0b, actual %0b", name, want, err);
            value_errs++;
        end
    endtask

    task automatic check_result();
        logic [31:0] exp;
        string       name;
        name = $sformatf("record %0d %s", index_q, kind_label(kind_q, op_q));
        case (kind_q)
            4'd2: begin
                expect_err(name, 1'b0);
                if (have_mtime && ((rdata > last_mtime) !== 1'b1)) begin
                    $display("FAIL %s: expected above %h, actual %h", name, last_mtime, rdata);
                    value_errs++;
                end
                have_mtime = 1'b1;
                last_mtime = rdata;
            end
            4'd3: expect_err(name, 1'b1);
            default: begin
                expect_err(name, 1'b0);
                if (op_q == op_store) begin
                    apply_store(addr_q, size_q, wdata_q);
                end else begin
                    exp = (kind_q == 4'd1) ? exp_q : predict_load(addr_q, size_q, sign_q);
                    if (rdata !== exp) begin
                        $display("FAIL %s: expected %h, actual %h", name, exp, rdata);
                        value_errs++;
                    end
                end
            end
        endcase
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (done) begin
                done_count++;
                if (!pending) begin
                    $display("done pulse at %0t with no request outstanding", $time);
                    proto_errs++;
                end else begin
                    check_result();
                end
                pending = 1'b0;
            end else if (pending && !busy) begin
                $display("busy dropped at %0t before the done pulse", $time);
                proto_errs++;
            end else if (!pending && busy) begin
                $display("busy high at %0t with no request outstanding", $time);
                proto_errs++;
            end
            if (req && !busy) begin  // request taken on this edge
                if (!started && rdata !== 32'h0) begin
                    $display("rdata is %h after reset instead of zero", rdata);
                    proto_errs++;
                end
                op_q    = op;
                size_q  = size;
                sign_q  = sign;
                addr_q  = addr;
                wdata_q = wdata;
                exp_q   = expect_val;
                kind_q  = kind;
                index_q = index;
                pending = 1'b1;
                started = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_mem_subsys.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_subsys
    import lsu_pkg::*;
();

    localparam int sram_words   = 1024;
    localparam int max_recs     = 64;
    localparam int reset_cycles = 16;
    localparam int clk_period   = 4;

    logic         clk;
    logic         rst_n;
    logic         req;
    lsu_op_e      op;
    lsu_size_e    size;
    logic         sign;
    logic [31:0]  addr;
    logic [31:0]  wdata;
    logic [31:0]  rdata;
    logic         done;
    logic         err;
    logic         busy;
    logic [3:0]   rec_kind;
    logic [31:0]  rec_expect;
    logic [7:0]   rec_index;
    logic [111:0] recs [max_recs];  // kind op size sign addr wdata expect
    int           n_recs;
    int           value_errs;
    int           proto_errs;
    int           done_count;
    logic [31:0]  rnd;

    always #(clk_period / 2) clk = ~clk;

    mem_subsys_top #(
        .sram_words (sram_words)
    ) u_mem_subsys_top (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .op    (op),
        .size  (size),
        .sign  (sign),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .done  (done),
        .err   (err),
        .busy  (busy)
    );

    mem_checker #(
        .sram_words (sram_words)
    ) u_mem_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .op         (op),
        .size       (size),
        .sign       (sign),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .done       (done),
        .err        (err),
        .busy       (busy),
        .kind       (rec_kind),
        .expect_val (rec_expect),
        .index      (rec_index),
        .value_errs (value_errs),
        .proto_errs (proto_errs),
        .done_count (done_count)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // one request on a falling edge and a wait for its done
    task automatic run_record(input int i);
        logic [111:0] r;
        r          = recs[i];
        rec_kind   = r[111:108];
        op         = lsu_op_e'(r[104]);
        size       = lsu_size_e'(r[101:100]);
        sign       = r[96];
        addr       = r[95:64];
        wdata      = r[63:32];
        rec_expect = r[31:0];
        rec_index  = 8'(i);
        req        = 1'b1;
        @(negedge clk);
        req = 1'b0;  // taken on the rising edge in between
        while (!done) begin
            @(negedge clk);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        req        = 1'b0;
        op         = op_load;
        size       = size_word;
        sign       = 1'b0;
        addr       = '0;
        wdata      = '0;
        rec_kind   = '0;
        rec_expect = '0;
        rec_index  = '0;
        rnd        = 32'ha8e4;
        n_recs     = 0;
        for (int i = 0; i < max_recs; i++) begin
            recs[i] = '1;  // all ones marks an unused slot
        end
        $readmemh("verification/lsu_stimulus.txt", recs);
        while (n_recs < max_recs && recs[n_recs][111:108] != 4'hf) begin
            n_recs++;
        end
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (n_recs == 0) begin
            $display("no records could be read from verification/lsu_stimulus.txt");
        end
        for (int i = 0; i < n_recs; i++) begin
            rnd = next_random(rnd);
            repeat (rnd[1:0]) @(negedge clk);  // idle gap of 0 to 3 cycles
            run_record(i);
        end
        repeat (3) @(negedge clk);
        $display("errors: %0d value, %0d protocol; %0d done pulses for %0d records",
                 value_errs, proto_errs, done_count, n_recs);
        if (n_recs > 0 && value_errs == 0 && proto_errs == 0 && done_count == n_recs) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        wait (n_recs > 0);
        #((n_recs * 20 + reset_cycles) * clk_period);
        $display("timeout: the run did not finish within %0d cycles",
                 n_recs * 20 + reset_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/lsu_stimulus.txt
// columns: kind op size sign addr wdata expect
// kind 0 model 1 literal 2 mtime 3 err expected; op 1 store; size 1 byte 2 half 3 word
0_1_3_0_80000010_11223344_00000000
0_1_1_0_80000011_000000aa_00000000
0_1_2_0_80000012_0000beef_00000000
0_0_3_0_80000010_00000000_00000000
1_0_3_0_80000010_00000000_beefaa44
0_1_3_0_80000020_80ff7f01_00000000
1_0_1_1_80000020_00000000_00000001
1_0_1_1_80000021_00000000_0000007f
1_0_1_1_80000022_00000000_ffffffff
1_0_1_1_80000023_00000000_ffffff80
0_0_1_0_80000022_00000000_00000000
1_0_1_0_80000023_00000000_00000080
1_0_2_1_80000020_00000000_00007f01
1_0_2_1_80000022_00000000_ffff80ff
1_0_2_0_80000022_00000000_000080ff
0_0_2_0_80000020_00000000_00000000
0_0_1_1_80000021_00000000_00000000
2_0_3_0_0200bff8_00000000_00000000
2_0_3_0_0200bff8_00000000_00000000
3_1_3_0_0200bff8_12345678_00000000
3_0_3_0_10000000_00000000_00000000
3_1_3_0_40000000_deadbeef_00000000
0_0_3_0_80000010_00000000_00000000
0_1_1_0_80000013_00000055_00000000
0_0_3_0_80000010_00000000_00000000

//--- list.f
source/lsu_pkg.sv
source/mem_map_pkg.sv
source/lsu.sv
source/lsu_xbar.sv
source/sram_slave.sv
source/clint_slave.sv
source/mem_subsys_top.sv
verification/mem_checker.sv
verification/tb_mem_subsys.sv

//--- Bender.yml
package:
  name: mem_subsys

sources:
  - source/lsu_pkg.sv
  - source/mem_map_pkg.sv
  - source/lsu.sv
  - source/lsu_xbar.sv
  - source/sram_slave.sv
  - source/clint_slave.sv
  - source/mem_subsys_top.sv
  - target: test
    files:
      - verification/mem_checker.sv
      - verification/tb_mem_subsys.sv
